// File: rv_pkg.sv
package rv_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;

  // RV32I base opcodes
  localparam opcode_t OP_LUI      = 7'b0110111;
  localparam opcode_t OP_AUIPC    = 7'b0010111;
  localparam opcode_t OP_JAL      = 7'b1101111;
  localparam opcode_t OP_JALR     = 7'b1100111;
  localparam opcode_t OP_BRANCH   = 7'b1100011;
  localparam opcode_t OP_LOAD     = 7'b0000011;
  localparam opcode_t OP_STORE    = 7'b0100011;
  localparam opcode_t OP_REG_IMM  = 7'b0010011;
  localparam opcode_t OP_REG_REG  = 7'b0110011;
  localparam opcode_t OP_MISC_MEM = 7'b0001111;
  localparam opcode_t OP_SYSTEM   = 7'b1110011;

  // Branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // ALU group selection shared by OP and OP-IMM
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SR      = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // Word width for LW and SW
  localparam funct3_t F3_WORD = 3'b010;

  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JAL, PC_JALR} pc_sel_e;

  typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_sel_e;

endpackage

// File: rv_decode_if.sv
`timescale 1ns/1ps

interface rv_decode_if;
  import rv_pkg::*;

  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  xlen_t    imm;
  alu_op_e  alu_op;
  logic     use_imm;
  // AUIPC takes the PC as operand A
  logic     use_pc;
  logic     reg_we;
  wb_sel_e  wb_sel;
  logic     is_branch;
  funct3_t  funct3;
  pc_sel_e  pc_sel;
  logic     is_store;
  logic     halt;

  modport dec (output rs1, rs2, rd, imm, alu_op, use_imm, use_pc, reg_we, wb_sel,
               is_branch, funct3, pc_sel, is_store, halt);
  modport rf (input rs1, rs2, rd, reg_we);
  modport alu (input imm, alu_op, use_imm, use_pc, is_branch, funct3);
  modport fetch (input imm, pc_sel);

endinterface

// File: rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
  input rv_pkg::xlen_t i_insn,
  rv_decode_if.dec     dec
);
  import rv_pkg::*;

  opcode_t    opcode;
  funct3_t    funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  logic       f7_checked;
  logic       alt_ok;
  logic       f7_legal;

  assign opcode = i_insn[6:0];
  assign funct3 = i_insn[14:12];
  assign funct7 = i_insn[31:25];

  assign dec.rd     = i_insn[11:7];
  assign dec.rs1    = i_insn[19:15];
  assign dec.rs2    = i_insn[24:20];
  assign dec.funct3 = funct3;

  // Sign-extended immediates for each format
  assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
  assign imm_s = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
  assign imm_b = {{20{i_insn[31]}}, i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
  assign imm_u = {i_insn[31:12], 12'b0};
  assign imm_j = {{12{i_insn[31]}}, i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};

  // funct7 legality for the ALU groups; only shifts look at it in OP-IMM
  assign f7_checked = (opcode == OP_REG_REG) || (funct3 == F3_SLL) || (funct3 == F3_SR);
  assign alt_ok     = (funct3 == F3_SR) || (funct3 == F3_ADD_SUB && opcode == OP_REG_REG);
  assign f7_legal   = !f7_checked || (funct7 == 7'd0) || (funct7 == FUNCT7_ALT && alt_ok);

  always_comb begin
    // No-op defaults
    dec.imm       = imm_i;
    dec.alu_op    = ALU_ADD;
    dec.use_imm   = 1'b0;
    dec.use_pc    = 1'b0;
    dec.reg_we    = 1'b0;
    dec.wb_sel    = WB_ALU;
    dec.is_branch = 1'b0;
    dec.pc_sel    = PC_SEQ;
    dec.is_store  = 1'b0;
    dec.halt      = 1'b0;
    case (opcode)
      OP_LUI: begin
        dec.imm     = imm_u;
        dec.alu_op  = ALU_PASS_B;
        dec.use_imm = 1'b1;
        dec.reg_we  = 1'b1;
      end
      OP_AUIPC: begin
        dec.imm     = imm_u;
        dec.use_pc  = 1'b1;
        dec.use_imm = 1'b1;
        dec.reg_we  = 1'b1;
      end
      OP_JAL: begin
        dec.imm    = imm_j;
        dec.pc_sel = PC_JAL;
        dec.reg_we = 1'b1;
        dec.wb_sel = WB_PC4;
      end
      OP_JALR: begin
        if (funct3 == 3'b000) begin
          dec.use_imm = 1'b1;
          dec.pc_sel  = PC_JALR;
          dec.reg_we  = 1'b1;
          dec.wb_sel  = WB_PC4;
        end
      end
      OP_BRANCH: begin
        dec.imm       = imm_b;
        dec.is_branch = 1'b1;
        dec.pc_sel    = PC_BRANCH;
      end
      OP_LOAD: begin
        dec.use_imm = 1'b1;
        dec.reg_we  = (funct3 == F3_WORD);
        dec.wb_sel  = WB_LOAD;
      end
      OP_STORE: begin
        dec.imm      = imm_s;
        dec.use_imm  = 1'b1;
        dec.is_store = (funct3 == F3_WORD);
      end
      OP_REG_IMM, OP_REG_REG: begin
        dec.use_imm = (opcode == OP_REG_IMM);
        dec.reg_we  = f7_legal;
        case (funct3)
          F3_ADD_SUB: dec.alu_op = (opcode == OP_REG_REG && funct7 == FUNCT7_ALT) ?
                                   ALU_SUB : ALU_ADD;
          F3_SLL:     dec.alu_op = ALU_SLL;
          F3_SLT:     dec.alu_op = ALU_SLT;
          F3_SLTU:    dec.alu_op = ALU_SLTU;
          F3_XOR:     dec.alu_op = ALU_XOR;
          F3_SR:      dec.alu_op = (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
          F3_OR:      dec.alu_op = ALU_OR;
          F3_AND:     dec.alu_op = ALU_AND;
          default:    dec.alu_op = ALU_ADD;
        endcase
      end
      OP_MISC_MEM: begin
        // FENCE has nothing to order in a single-cycle core
      end
      OP_SYSTEM: dec.halt = (i_insn[31:7] == 25'd0);
      default: begin
      end
    endcase
  end

endmodule

// File: rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic          clk,
  input  logic          rst,
  rv_decode_if.rf       rf,
  input  rv_pkg::xlen_t i_rd_data,
  output rv_pkg::xlen_t o_rs1_data,
  output rv_pkg::xlen_t o_rs2_data
);
  import rv_pkg::*;

  // x0 has no storage
  xlen_t regs [31:1];

  assign o_rs1_data = (rf.rs1 == '0) ? '0 : regs[rf.rs1];
  assign o_rs2_data = (rf.rs2 == '0) ? '0 : regs[rf.rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.reg_we && rf.rd != '0) begin
      regs[rf.rd] <= i_rd_data;
    end
  end

endmodule

// File: rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
  rv_decode_if.alu      alu,
  input  rv_pkg::xlen_t i_pc,
  input  rv_pkg::xlen_t i_rs1_data,
  input  rv_pkg::xlen_t i_rs2_data,
  output rv_pkg::xlen_t o_result,
  output logic          o_branch_taken
);
  import rv_pkg::*;

  xlen_t      op_a;
  xlen_t      op_b;
  logic [4:0] shamt;
  logic       cond;

  assign op_a  = alu.use_pc ? i_pc : i_rs1_data;
  assign op_b  = alu.use_imm ? alu.imm : i_rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu.alu_op)
      ALU_ADD:    o_result = op_a + op_b;
      ALU_SUB:    o_result = op_a - op_b;
      ALU_SLL:    o_result = op_a << shamt;
      ALU_SLT:    o_result = xlen_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU:   o_result = xlen_t'(op_a < op_b);
      ALU_XOR:    o_result = op_a ^ op_b;
      ALU_SRL:    o_result = op_a >> shamt;
      ALU_SRA:    o_result = $signed(op_a) >>> shamt;
      ALU_OR:     o_result = op_a | op_b;
      ALU_AND:    o_result = op_a & op_b;
      ALU_PASS_B: o_result = op_b;
      default:    o_result = op_a + op_b;
    endcase
  end

  // Branch compare always uses the two register values
  always_comb begin
    case (alu.funct3)
      F3_BEQ:  cond = (i_rs1_data == i_rs2_data);
      F3_BNE:  cond = (i_rs1_data != i_rs2_data);
      F3_BLT:  cond = ($signed(i_rs1_data) < $signed(i_rs2_data));
      F3_BGE:  cond = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      F3_BLTU: cond = (i_rs1_data < i_rs2_data);
      F3_BGEU: cond = (i_rs1_data >= i_rs2_data);
      // Reserved encodings fall through
      default: cond = 1'b0;
    endcase
  end

  assign o_branch_taken = alu.is_branch & cond;

endmodule

// File: rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch #(
  parameter rv_pkg::xlen_t RESET_PC = '0
) (
  input  logic          clk,
  input  logic          rst,
  rv_decode_if.fetch    fetch,
  input  logic          i_branch_taken,
  input  rv_pkg::xlen_t i_jalr_target,
  output rv_pkg::xlen_t o_pc,
  output rv_pkg::xlen_t o_pc_plus4
);
  import rv_pkg::*;

  xlen_t pc_imm;
  xlen_t pc_next;

  assign o_pc_plus4 = o_pc + 32'd4;
  assign pc_imm     = o_pc + fetch.imm;

  always_comb begin
    case (fetch.pc_sel)
      PC_BRANCH: pc_next = i_branch_taken ? pc_imm : o_pc_plus4;
      PC_JAL:    pc_next = pc_imm;
      // JALR drops bit 0 of the target
      PC_JALR:   pc_next = i_jalr_target & ~32'd1;
      default:   pc_next = o_pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_pc <= RESET_PC;
    end else begin
      o_pc <= pc_next;
    end
  end

endmodule

// File: rv_core.sv
`timescale 1ns/1ps

module rv_core #(
  parameter rv_pkg::xlen_t RESET_PC = '0
) (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::xlen_t i_insn,
  output rv_pkg::xlen_t o_pc,
  output rv_pkg::xlen_t o_dmem_addr,
  output rv_pkg::xlen_t o_dmem_wdata,
  output logic          o_dmem_we,
  input  rv_pkg::xlen_t i_dmem_rdata,
  output logic          o_halt
);
  import rv_pkg::*;

  rv_decode_if dec_if ();

  xlen_t rs1_data;
  xlen_t rs2_data;
  xlen_t alu_result;
  xlen_t pc_plus4;
  xlen_t rd_data;
  logic  branch_taken;

  rv_decoder decoder_inst (.i_insn(i_insn), .dec(dec_if));

  rv_regfile regfile_inst (
    .clk        (clk),
    .rst        (rst),
    .rf         (dec_if),
    .i_rd_data  (rd_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  rv_alu alu_inst (
    .alu            (dec_if),
    .i_pc           (o_pc),
    .i_rs1_data     (rs1_data),
    .i_rs2_data     (rs2_data),
    .o_result       (alu_result),
    .o_branch_taken (branch_taken)
  );

  rv_fetch #(.RESET_PC(RESET_PC)) fetch_inst (
    .clk            (clk),
    .rst            (rst),
    .fetch          (dec_if),
    .i_branch_taken (branch_taken),
    .i_jalr_target  (alu_result),
    .o_pc           (o_pc),
    .o_pc_plus4     (pc_plus4)
  );

  // Writeback source
  always_comb begin
    case (dec_if.wb_sel)
      WB_LOAD: rd_data = i_dmem_rdata;
      WB_PC4:  rd_data = pc_plus4;
      default: rd_data = alu_result;
    endcase
  end

  assign o_dmem_addr  = alu_result;
  assign o_dmem_wdata = rs2_data;
  // No stores while the core sits in reset
  assign o_dmem_we    = dec_if.is_store & ~rst;
  assign o_halt       = dec_if.halt;

endmodule

// File: rv_core_chk.sv
`timescale 1ns/1ps

module rv_core_chk (
  input logic          clk,
  input logic          rst,
  input rv_pkg::xlen_t i_insn,
  input rv_pkg::xlen_t o_pc,
  input logic          o_dmem_we
);
  import rv_pkg::*;

  int   fails = 0;
  logic is_ctrl;

  // Only jumps and branches leave the sequential path
  assign is_ctrl = (i_insn[6:0] == OP_JAL) || (i_insn[6:0] == OP_JALR) ||
                   (i_insn[6:0] == OP_BRANCH);

  no_store_in_reset: assert property (@(posedge clk) rst |-> !o_dmem_we)
    else begin
      fails++;
      $error("Store strobe high during reset");
    end

  pc_after_reset: assert property (@(posedge clk) $fell(rst) |-> o_pc == '0)
    else begin
      fails++;
      $error("PC is not zero in the first cycle after reset");
    end

  pc_aligned: assert property (@(posedge clk) disable iff (rst) o_pc[1:0] == 2'b00)
    else begin
      fails++;
      $error("PC is not word aligned");
    end

  pc_sequential: assert property (@(posedge clk) disable iff (rst)
                                  !is_ctrl |=> o_pc == $past(o_pc) + 32'd4)
    else begin
      fails++;
      $error("PC did not advance by 4 after a non-control instruction");
    end

endmodule

// File: tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
  import rv_pkg::*;

  logic  clk;
  logic  rst;
  xlen_t i_insn = '0;
  xlen_t i_dmem_rdata = '0;
  xlen_t o_pc;
  xlen_t o_dmem_addr;
  xlen_t o_dmem_wdata;
  logic  o_dmem_we;
  logic  o_halt;

  xlen_t       imem [0:511];
  xlen_t       dmem [0:255];
  xlen_t       ref_regs [0:31];
  logic [31:0] lfsr;
  int          n_insn;
  int          slot;
  int          n_sw_exp;
  int          n_stores;
  logic        built;
  // Stores the program is expected to make in order
  xlen_t       exp_addr [$];
  xlen_t       exp_data [$];
  string       exp_name [$];

  rv_core rv_core_inst (
    .clk          (clk),
    .rst          (rst),
    .i_insn       (i_insn),
    .o_pc         (o_pc),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata),
    .o_dmem_we    (o_dmem_we),
    .i_dmem_rdata (i_dmem_rdata),
    .o_halt       (o_halt)
  );

  bind rv_core rv_core_chk chk_inst (
    .clk(clk), .rst(rst), .i_insn(i_insn), .o_pc(o_pc), .o_dmem_we(o_dmem_we)
  );

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input xlen_t exp, input xlen_t act);
    $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic xlen_t rand_bits(input int n);
    xlen_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic xlen_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                  input funct3_t f3, input reg_idx_t rd, input opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic xlen_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                  input reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OP_STORE};
  endfunction

  function automatic xlen_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input funct3_t f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic xlen_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  // RV32I arithmetic rules
  function automatic xlen_t alu_ref(input funct3_t f3, input logic alt, input xlen_t a,
                                    input xlen_t b);
    case (f3)
      F3_ADD_SUB: return alt ? a - b : a + b;
      F3_SLL:     return a << b[4:0];
      F3_SLT:     return {31'd0, $signed(a) < $signed(b)};
      F3_SLTU:    return {31'd0, a < b};
      F3_XOR:     return a ^ b;
      F3_SR:      return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      F3_OR:      return a | b;
      default:    return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input funct3_t f3, input xlen_t a, input xlen_t b);
    case (f3)
      F3_BEQ:  return a == b;
      F3_BNE:  return a != b;
      F3_BLT:  return $signed(a) < $signed(b);
      F3_BGE:  return $signed(a) >= $signed(b);
      F3_BLTU: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic emit(input xlen_t w);
    imem[n_insn] = w;
    n_insn++;
  endtask

  task automatic load_const(input reg_idx_t rd, input xlen_t v);
    xlen_t hi;
    // Upper part rounded so the signed ADDI lands on v
    hi = v + 32'h800;
    emit({hi[31:12], rd, OP_LUI});
    emit(enc_i(v[11:0], rd, F3_ADD_SUB, rd, OP_REG_IMM));
    ref_regs[rd] = v;
  endtask

  task automatic store_at(input reg_idx_t rs, input xlen_t addr, input string name);
    emit(enc_s(addr[11:0], rs, 5'd0));
    exp_addr.push_back(addr);
    exp_data.push_back(ref_regs[rs]);
    exp_name.push_back(name);
    n_sw_exp++;
  endtask

  task automatic store_check(input reg_idx_t rs, input string name);
    xlen_t addr;
    addr = 32'h100 + (xlen_t'(slot % 192) << 2);
    slot++;
    store_at(rs, addr, name);
  endtask

  // Store that must never execute
  task automatic skip_store();
    emit(enc_s(12'h3fc, 5'd1, 5'd0));
  endtask

  task automatic alu_check(input funct3_t f3, input logic alt, input logic use_imm,
                           input string name);
    xlen_t       r;
    logic [11:0] imm;
    r = rand_bits(12);
    imm = r[11:0];
    if (f3 == F3_SLL || f3 == F3_SR) begin
      imm = {1'b0, alt, 5'd0, r[4:1], 1'b1};
    end
    if (use_imm) begin
      emit(enc_i(imm, 5'd1, f3, 5'd3, OP_REG_IMM));
      ref_regs[3] = alu_ref(f3, alt, ref_regs[1], {{20{imm[11]}}, imm});
    end else begin
      emit({alt ? FUNCT7_ALT : 7'd0, 5'd2, 5'd1, f3, 5'd3, OP_REG_REG});
      ref_regs[3] = alu_ref(f3, alt, ref_regs[1], ref_regs[2]);
    end
    store_check(5'd3, name);
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Fetch on the falling edge and return load data a little later
  always @(negedge clk) begin
    i_insn = imem[o_pc[10:2]];
    #1 i_dmem_rdata = dmem[o_dmem_addr[9:2]];
  end

  always @(posedge clk) begin
    if (o_dmem_we === 1'b1) begin
      dmem[o_dmem_addr[9:2]] <= o_dmem_wdata;
      assert (exp_addr.size() != 0) else stop_with_error("Store seen with none expected");
      assert (o_dmem_addr == exp_addr[0])
        else report_mismatch({exp_name[0], " address"}, exp_addr[0], o_dmem_addr);
      assert (o_dmem_wdata == exp_data[0])
        else report_mismatch({exp_name[0], " data"}, exp_data[0], o_dmem_wdata);
      void'(exp_addr.pop_front());
      void'(exp_data.pop_front());
      void'(exp_name.pop_front());
      n_stores++;
    end
    if (!rst && o_halt === 1'b1) begin
      assert (exp_addr.size() == 0 && n_stores == n_sw_exp &&
              rv_core_inst.chk_inst.fails == 0) begin
        $display("TESTBENCH PASSED");
        $finish;
      end else begin
        stop_with_error($sformatf("Halt after %0d of %0d stores, %0d checker failures",
                                  n_stores, n_sw_exp, rv_core_inst.chk_inst.fails));
      end
    end
  end

  initial begin
    wait (built);
    #((n_insn + 8 + 20) * 10);
    stop_with_error("Timeout, the core never reached ECALL");
  end

  initial begin
    xlen_t    a;
    xlen_t    b;
    xlen_t    r;
    xlen_t    addr;
    reg_idx_t rs1;
    reg_idx_t rs2;
    rst = 1'b1;
    built = 1'b0;
    lfsr = 32'h878a;
    n_insn = 0;
    slot = 0;
    n_sw_exp = 0;
    n_stores = 0;
    for (int i = 0; i < 512; i++) begin
      imem[i] = 32'h00000073;
    end
    for (int i = 0; i < 256; i++) begin
      dmem[i] = 32'h5a5a0000 ^ (xlen_t'(i) << 2);
    end
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end

    // First instruction is a store that sits on the bus through reset
    store_check(5'd0, "store after reset");

    // The first ALU round forces a sign difference and a nonzero shift
    for (int round = 0; round < 3; round++) begin
      a = rand_bits(32);
      b = rand_bits(32);
      if (round == 0) begin
        a[31] = 1'b1;
        b[31] = 1'b0;
        b[0] = 1'b1;
      end
      load_const(5'd1, a);
      load_const(5'd2, b);
      for (int f = 0; f < 8; f++) begin
        alu_check(funct3_t'(f), 1'b0, 1'b0, $sformatf("reg f3=%0d", f));
        alu_check(funct3_t'(f), 1'b0, 1'b1, $sformatf("imm f3=%0d", f));
      end
      alu_check(F3_ADD_SUB, 1'b1, 1'b0, "sub");
      alu_check(F3_SR, 1'b1, 1'b0, "sra");
      alu_check(F3_SR, 1'b1, 1'b1, "srai");
    end

    emit(enc_i(12'h07b, 5'd0, F3_ADD_SUB, 5'd0, OP_REG_IMM));
    store_check(5'd0, "x0 write");
    emit(32'h0ff0000f);

    r = rand_bits(6);
    addr = {24'd0, r[5:0], 2'b00};
    load_const(5'd5, rand_bits(32));
    store_at(5'd5, addr, "sw round trip");
    emit(enc_i(addr[11:0], 5'd0, F3_WORD, 5'd6, OP_LOAD));
    ref_regs[6] = ref_regs[5];
    store_check(5'd6, "lw round trip");

    // Three operand orders give every branch a taken and a not-taken case
    load_const(5'd10, rand_bits(32) | 32'h80000000);
    load_const(5'd11, rand_bits(32) & 32'h7fffffff);
    for (int f = 0; f < 8; f++) begin
      for (int k = 0; k < 3; k++) begin
        if (f == 2 || f == 3) begin
          continue;
        end
        rs1 = (k == 2) ? 5'd11 : 5'd10;
        rs2 = (k == 1) ? 5'd11 : 5'd10;
        emit(enc_b(13'd8, rs2, rs1, funct3_t'(f)));
        if (branch_ref(funct3_t'(f), ref_regs[rs1], ref_regs[rs2])) begin
          skip_store();
        end else begin
          store_check(5'd10, $sformatf("branch f3=%0d case %0d", f, k));
        end
      end
    end

    ref_regs[8] = (xlen_t'(n_insn) << 2) + 32'd4;
    emit(enc_j(21'd8, 5'd8));
    skip_store();
    store_check(5'd8, "jal link");

    // Target plus one checks that bit 0 is cleared
    load_const(5'd9, (xlen_t'(n_insn) + 32'd4) << 2);
    ref_regs[12] = (xlen_t'(n_insn) << 2) + 32'd4;
    emit(enc_i(12'd1, 5'd9, 3'b000, 5'd12, OP_JALR));
    skip_store();
    store_check(5'd12, "jalr link");

    r = rand_bits(20);
    ref_regs[13] = (xlen_t'(n_insn) << 2) + {r[19:0], 12'd0};
    emit({r[19:0], 5'd13, OP_AUIPC});
    store_check(5'd13, "auipc");

    emit(32'h00000073);
    built = 1'b1;

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

// File: sim.f
rv_pkg.sv
rv_decode_if.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_fetch.sv
rv_core.sv
rv_core_chk.sv
tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_rv_core
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
